// File: design/rvc_pkg.sv
// RVC expander definitions
package rvc_pkg;

  localparam int unsigned ILEN = 32;
  localparam int unsigned CLEN = 16;

  typedef logic [ILEN-1:0] instr_t;

  // --------------------
  // RV32I major opcodes
  // --------------------
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

  // low two bits of a fetched word
  localparam logic [1:0] QUAD_C0   = 2'b00;
  localparam logic [1:0] QUAD_C1   = 2'b01;
  localparam logic [1:0] QUAD_C2   = 2'b10;
  localparam logic [1:0] QUAD_NONE = 2'b11;

  // --------------------
  // compressed funct3 rows
  // --------------------
  localparam logic [2:0] C0_ADDI4SPN = 3'b000;
  localparam logic [2:0] C0_FLD      = 3'b001;
  localparam logic [2:0] C0_LW       = 3'b010;
  localparam logic [2:0] C0_FLW      = 3'b011;
  localparam logic [2:0] C0_FSD      = 3'b101;
  localparam logic [2:0] C0_SW       = 3'b110;
  localparam logic [2:0] C0_FSW      = 3'b111;

  localparam logic [2:0] C1_ADDI         = 3'b000;
  localparam logic [2:0] C1_JAL          = 3'b001;
  localparam logic [2:0] C1_LI           = 3'b010;
  localparam logic [2:0] C1_LUI_ADDI16SP = 3'b011;
  localparam logic [2:0] C1_MISC_ALU     = 3'b100;
  localparam logic [2:0] C1_J            = 3'b101;
  localparam logic [2:0] C1_BEQZ         = 3'b110;
  localparam logic [2:0] C1_BNEZ         = 3'b111;

  localparam logic [2:0] C2_SLLI        = 3'b000;
  localparam logic [2:0] C2_FLDSP       = 3'b001;
  localparam logic [2:0] C2_LWSP        = 3'b010;
  localparam logic [2:0] C2_FLWSP       = 3'b011;
  localparam logic [2:0] C2_JALR_MV_ADD = 3'b100;
  localparam logic [2:0] C2_FSDSP       = 3'b101;
  localparam logic [2:0] C2_SWSP        = 3'b110;
  localparam logic [2:0] C2_FSWSP       = 3'b111;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // rd'/rs1'/rs2' select x8..x15
  localparam logic [1:0] PRIME_PREFIX = 2'b01;

  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

  // --------------------
  // compressed formats
  // --------------------
  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rd_rs1;
    logic [4:0] rs2;
    logic [1:0] op;
  } cr_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [4:0] rd_rs1;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } ci_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [5:0] imm;
    logic [4:0] rs2;
    logic [1:0] op;
  } css_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rd_p;
    logic [1:0] op;
  } ciw_t;

  // shared by CL and CS
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rd_rs2_p;
    logic [1:0] op;
  } cl_t;

  typedef struct packed {
    logic [5:0] funct6;
    logic [2:0] rd_rs1_p;
    logic [1:0] funct2;
    logic [2:0] rs2_p;
    logic [1:0] op;
  } ca_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] off_hi;
    logic [2:0] rs1_p;
    logic [4:0] off_lo;
    logic [1:0] op;
  } cb_t;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  op;
  } cj_t;

  typedef union packed {
    cr_t  cr;
    ci_t  ci;
    css_t css;
    ciw_t ciw;
    cl_t  cl;
    ca_t  ca;
    cb_t  cb;
    cj_t  cj;
  } c_instr_u;

endpackage

// File: design/rvc_quadrant0.sv
// RVC quadrant 0 expander
`timescale 1ns/10ps

module rvc_quadrant0 (
  input  rvc_pkg::c_instr_u c_instr_i,
  output rvc_pkg::instr_t   instr_o,
  output logic              illegal_o
);

  // prime registers widened to x8-x15
  logic [4:0] ciw_rd;
  logic [4:0] cl_rs1;
  logic [4:0] cl_rd_rs2;

  assign ciw_rd    = {rvc_pkg::PRIME_PREFIX, c_instr_i.ciw.rd_p};
  assign cl_rs1    = {rvc_pkg::PRIME_PREFIX, c_instr_i.cl.rs1_p};
  assign cl_rd_rs2 = {rvc_pkg::PRIME_PREFIX, c_instr_i.cl.rd_rs2_p};

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    unique case (c_instr_i.ciw.funct3)
      rvc_pkg::C0_ADDI4SPN: begin
        // addi rd', x2, nzuimm[9:2]
        instr_o = {2'b00, c_instr_i.ciw.imm[5:2], c_instr_i.ciw.imm[7:6],
                   c_instr_i.ciw.imm[0], c_instr_i.ciw.imm[1], 2'b00,
                   rvc_pkg::REG_SP, 3'b000, ciw_rd, rvc_pkg::OPCODE_OP_IMM};
        // zero immediate covers the all-zero illegal parcel too
        illegal_o = (c_instr_i.ciw.imm == 8'h00);
      end

      rvc_pkg::C0_LW: begin
        // lw rd', uimm[6:2](rs1')
        instr_o = {5'b00000, c_instr_i.cl.imm_lo[0], c_instr_i.cl.imm_hi,
                   c_instr_i.cl.imm_lo[1], 2'b00, cl_rs1, 3'b010, cl_rd_rs2,
                   rvc_pkg::OPCODE_LOAD};
      end

      rvc_pkg::C0_SW: begin
        // sw rs2', uimm[6:2](rs1')
        instr_o = {5'b00000, c_instr_i.cl.imm_lo[0], c_instr_i.cl.imm_hi[2],
                   cl_rd_rs2, cl_rs1, 3'b010, c_instr_i.cl.imm_hi[1:0],
                   c_instr_i.cl.imm_lo[1], 2'b00, rvc_pkg::OPCODE_STORE};
      end

      // no FPU behind this expander
      rvc_pkg::C0_FLD, rvc_pkg::C0_FLW, rvc_pkg::C0_FSD, rvc_pkg::C0_FSW: begin
        illegal_o = 1'b1;
      end

      // reserved row
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: design/rvc_quadrant1.sv
// RVC quadrant 1 expander
`timescale 1ns/10ps

module rvc_quadrant1 (
  input  rvc_pkg::c_instr_u c_instr_i,
  output rvc_pkg::instr_t   instr_o,
  output logic              illegal_o
);

  logic [4:0]  rd_p;
  logic [4:0]  rs2_p;
  logic [4:0]  br_rs1;
  // c.j/c.jal offset, bit 0 is implied zero
  logic [11:1] j_off;
  // c.beqz/c.bnez offset, bit 0 is implied zero
  logic [8:1]  b_off;
  logic [11:0] sp_imm;

  assign rd_p   = {rvc_pkg::PRIME_PREFIX, c_instr_i.ca.rd_rs1_p};
  assign rs2_p  = {rvc_pkg::PRIME_PREFIX, c_instr_i.ca.rs2_p};
  assign br_rs1 = {rvc_pkg::PRIME_PREFIX, c_instr_i.cb.rs1_p};

  // undo the CJ bit scramble
  assign j_off = {c_instr_i.cj.target[10], c_instr_i.cj.target[6],
                  c_instr_i.cj.target[8:7], c_instr_i.cj.target[4],
                  c_instr_i.cj.target[5], c_instr_i.cj.target[0],
                  c_instr_i.cj.target[9], c_instr_i.cj.target[3:1]};

  assign b_off = {c_instr_i.cb.off_hi[2], c_instr_i.cb.off_lo[4:3],
                  c_instr_i.cb.off_lo[0], c_instr_i.cb.off_hi[1:0],
                  c_instr_i.cb.off_lo[2:1]};

  // nzimm[9:4] of c.addi16sp, sign extended
  assign sp_imm = {{3{c_instr_i.ci.imm_hi}}, c_instr_i.ci.imm_lo[2:1],
                   c_instr_i.ci.imm_lo[3], c_instr_i.ci.imm_lo[0],
                   c_instr_i.ci.imm_lo[4], 4'b0000};

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    unique case (c_instr_i.ci.funct3)
      rvc_pkg::C1_ADDI: begin
        // c.nop is simply addi x0, x0, 0
        instr_o = {{7{c_instr_i.ci.imm_hi}}, c_instr_i.ci.imm_lo, c_instr_i.ci.rd_rs1,
                   3'b000, c_instr_i.ci.rd_rs1, rvc_pkg::OPCODE_OP_IMM};
      end

      rvc_pkg::C1_LI: begin
        instr_o = {{7{c_instr_i.ci.imm_hi}}, c_instr_i.ci.imm_lo, rvc_pkg::REG_ZERO,
                   3'b000, c_instr_i.ci.rd_rs1, rvc_pkg::OPCODE_OP_IMM};
      end

      rvc_pkg::C1_LUI_ADDI16SP: begin
        if (c_instr_i.ci.rd_rs1 == rvc_pkg::REG_SP) begin
          // addi x2, x2, nzimm
          instr_o = {sp_imm, rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP,
                     rvc_pkg::OPCODE_OP_IMM};
        end else begin
          instr_o = {{15{c_instr_i.ci.imm_hi}}, c_instr_i.ci.imm_lo,
                     c_instr_i.ci.rd_rs1, rvc_pkg::OPCODE_LUI};
        end
        illegal_o = ({c_instr_i.ci.imm_hi, c_instr_i.ci.imm_lo} == 6'd0);
      end

      rvc_pkg::C1_MISC_ALU: begin
        unique case (c_instr_i.ca.funct6[1:0])
          2'b00, 2'b01: begin
            // srli / srai, bit 10 picks the arithmetic form
            instr_o = {1'b0, c_instr_i.cb.off_hi[0], 4'b0000, c_instr_i.cb.off_hi[2],
                       c_instr_i.cb.off_lo, rd_p, 3'b101, rd_p, rvc_pkg::OPCODE_OP_IMM};
          end
          2'b10: begin
            instr_o = {{7{c_instr_i.cb.off_hi[2]}}, c_instr_i.cb.off_lo, rd_p, 3'b111,
                       rd_p, rvc_pkg::OPCODE_OP_IMM};
          end
          default: begin
            unique case ({c_instr_i.ca.funct6[2], c_instr_i.ca.funct2})
              3'b000: instr_o = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p, rvc_pkg::OPCODE_OP};
              3'b001: instr_o = {7'b0000000, rs2_p, rd_p, 3'b100, rd_p, rvc_pkg::OPCODE_OP};
              3'b010: instr_o = {7'b0000000, rs2_p, rd_p, 3'b110, rd_p, rvc_pkg::OPCODE_OP};
              3'b011: instr_o = {7'b0000000, rs2_p, rd_p, 3'b111, rd_p, rvc_pkg::OPCODE_OP};
              // subw/addw and the Zcb slots
              default: illegal_o = 1'b1;
            endcase
          end
        endcase
      end

      rvc_pkg::C1_JAL, rvc_pkg::C1_J: begin
        // c.jal links to ra, c.j discards the link
        instr_o = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                   (c_instr_i.cj.funct3 == rvc_pkg::C1_JAL) ? rvc_pkg::REG_RA
                                                            : rvc_pkg::REG_ZERO,
                   rvc_pkg::OPCODE_JAL};
      end

      rvc_pkg::C1_BEQZ, rvc_pkg::C1_BNEZ: begin
        // funct3 bit 0 gives beq vs bne
        instr_o = {{4{b_off[8]}}, b_off[7:5], rvc_pkg::REG_ZERO, br_rs1,
                   2'b00, c_instr_i.cb.funct3[0], b_off[4:1], b_off[8],
                   rvc_pkg::OPCODE_BRANCH};
      end
    endcase
  end

endmodule

// File: design/rvc_quadrant2.sv
// RVC quadrant 2 expander
`timescale 1ns/10ps

module rvc_quadrant2 (
  input  rvc_pkg::c_instr_u c_instr_i,
  output rvc_pkg::instr_t   instr_o,
  output logic              illegal_o
);

  logic rs2_zero;
  logic rd_zero;

  assign rs2_zero = (c_instr_i.cr.rs2 == rvc_pkg::REG_ZERO);
  assign rd_zero  = (c_instr_i.cr.rd_rs1 == rvc_pkg::REG_ZERO);

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    unique case (c_instr_i.ci.funct3)
      rvc_pkg::C2_SLLI: begin
        instr_o = {6'b000000, c_instr_i.ci.imm_hi, c_instr_i.ci.imm_lo,
                   c_instr_i.ci.rd_rs1, 3'b001, c_instr_i.ci.rd_rs1,
                   rvc_pkg::OPCODE_OP_IMM};
      end

      rvc_pkg::C2_LWSP: begin
        // lw rd, uimm[7:2](x2)
        instr_o = {4'b0000, c_instr_i.ci.imm_lo[1:0], c_instr_i.ci.imm_hi,
                   c_instr_i.ci.imm_lo[4:2], 2'b00, rvc_pkg::REG_SP, 3'b010,
                   c_instr_i.ci.rd_rs1, rvc_pkg::OPCODE_LOAD};
        illegal_o = (c_instr_i.ci.rd_rs1 == rvc_pkg::REG_ZERO);
      end

      rvc_pkg::C2_SWSP: begin
        // sw rs2, uimm[7:2](x2)
        instr_o = {4'b0000, c_instr_i.css.imm[1:0], c_instr_i.css.imm[5],
                   c_instr_i.css.rs2, rvc_pkg::REG_SP, 3'b010,
                   c_instr_i.css.imm[4:2], 2'b00, rvc_pkg::OPCODE_STORE};
      end

      // --------------------
      // register row
      // --------------------
      rvc_pkg::C2_JALR_MV_ADD: begin
        if (!c_instr_i.cr.funct4[0]) begin
          if (rs2_zero) begin
            // c.jr
            instr_o = {12'h000, c_instr_i.cr.rd_rs1, 3'b000, rvc_pkg::REG_ZERO,
                       rvc_pkg::OPCODE_JALR};
            illegal_o = rd_zero;
          end else begin
            // c.mv
            instr_o = {7'b0000000, c_instr_i.cr.rs2, rvc_pkg::REG_ZERO, 3'b000,
                       c_instr_i.cr.rd_rs1, rvc_pkg::OPCODE_OP};
          end
        end else if (rs2_zero && rd_zero) begin
          instr_o = rvc_pkg::INSTR_EBREAK;
        end else if (rs2_zero) begin
          // c.jalr links to ra
          instr_o = {12'h000, c_instr_i.cr.rd_rs1, 3'b000, rvc_pkg::REG_RA,
                     rvc_pkg::OPCODE_JALR};
        end else begin
          // c.add
          instr_o = {7'b0000000, c_instr_i.cr.rs2, c_instr_i.cr.rd_rs1, 3'b000,
                     c_instr_i.cr.rd_rs1, rvc_pkg::OPCODE_OP};
        end
      end

      // FP stack rows, on RV64 these would be ldsp/sdsp
      rvc_pkg::C2_FLDSP, rvc_pkg::C2_FLWSP, rvc_pkg::C2_FSDSP, rvc_pkg::C2_FSWSP: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: design/rvc_expander.sv
// RVC expander top level
`timescale 1ns/10ps

module rvc_expander (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            valid_i,
  input  rvc_pkg::instr_t instr_i,
  output logic            valid_o,
  output logic            illegal_o,
  output logic            compressed_o,
  output rvc_pkg::instr_t instr_o
);

  rvc_pkg::c_instr_u c_instr;
  rvc_pkg::instr_t   q0_instr;
  rvc_pkg::instr_t   q1_instr;
  rvc_pkg::instr_t   q2_instr;
  logic              q0_illegal;
  logic              q1_illegal;
  logic              q2_illegal;
  rvc_pkg::instr_t   exp_instr;
  rvc_pkg::instr_t   instr_d;
  logic              illegal_d;
  logic              compressed_d;

  assign c_instr = instr_i[rvc_pkg::CLEN-1:0];

  // all three quadrants decode the same parcel in parallel
  rvc_quadrant0 i_quadrant0 (
    .c_instr_i (c_instr),
    .instr_o   (q0_instr),
    .illegal_o (q0_illegal)
  );

  rvc_quadrant1 i_quadrant1 (
    .c_instr_i (c_instr),
    .instr_o   (q1_instr),
    .illegal_o (q1_illegal)
  );

  rvc_quadrant2 i_quadrant2 (
    .c_instr_i (c_instr),
    .instr_o   (q2_instr),
    .illegal_o (q2_illegal)
  );

  always_comb begin
    exp_instr    = instr_i;
    illegal_d    = 1'b0;
    compressed_d = 1'b1;

    unique case (instr_i[1:0])
      rvc_pkg::QUAD_C0: begin
        exp_instr = q0_instr;
        illegal_d = q0_illegal;
      end
      rvc_pkg::QUAD_C1: begin
        exp_instr = q1_instr;
        illegal_d = q1_illegal;
      end
      rvc_pkg::QUAD_C2: begin
        exp_instr = q2_instr;
        illegal_d = q2_illegal;
      end
      rvc_pkg::QUAD_NONE: begin
        compressed_d = 1'b0;
      end
    endcase

    // decode stage gets the offending word untouched
    instr_d = illegal_d ? instr_i : exp_instr;
  end

  // --------------------
  // fetch to decode register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o      <= 1'b0;
      instr_o      <= '0;
      illegal_o    <= 1'b0;
      compressed_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // data holds while no word arrives
      if (valid_i) begin
        instr_o      <= instr_d;
        illegal_o    <= illegal_d;
        compressed_o <= compressed_d;
      end
    end
  end

  // --------------------
  // checks
  // --------------------
  a_full_word_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !compressed_o |-> !illegal_o)
    else $error("illegal flag raised on an uncompressed word");

  a_instr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> !$isunknown(instr_o))
    else $error("expanded instruction has unknown bits");

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !valid_o)
    else $error("valid_o high during reset");

endmodule

// File: sim/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release just after an edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: sim/tb_rvc_expander.sv
// RVC expander testbench
`timescale 1ns/10ps

module tb_rvc_expander;

  localparam string STIM_FILE     = "sim/rvc_stimulus.txt";
  localparam int    DRIVE_DELAY   = 1;
  localparam int    NUM_RANDOM    = 16;
  localparam int    GAP_EVERY     = 5;
  localparam int    RESET_TIMEOUT = 50;
  localparam int    DRAIN_TIMEOUT = 20;

  logic            clk;
  logic            rst_n;
  logic            valid;
  rvc_pkg::instr_t instr;
  logic            out_valid;
  logic            out_illegal;
  logic            out_compressed;
  rvc_pkg::instr_t out_instr;

  // vectors as read from the file
  rvc_pkg::instr_t stim_word_q[$];
  rvc_pkg::instr_t stim_instr_q[$];
  logic            stim_illegal_q[$];
  logic            stim_compressed_q[$];

  // words in flight, oldest first
  rvc_pkg::instr_t exp_instr_q[$];
  logic            exp_illegal_q[$];
  logic            exp_compressed_q[$];

  logic [31:0] lfsr_state = 32'h7c6e_da33;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rvc_expander i_rvc_expander (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .valid_i      (valid),
    .instr_i      (instr),
    .valid_o      (out_valid),
    .illegal_o    (out_illegal),
    .compressed_o (out_compressed),
    .instr_o      (out_instr)
  );

  // --------------------
  // helpers
  // --------------------
  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_instr(input string name, input rvc_pkg::instr_t actual,
                             input rvc_pkg::instr_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  // galois form, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0000_0000);
  endfunction

  task automatic take_random_word(output rvc_pkg::instr_t word);
    word = '0;
    for (int b = 0; b < 32; b++) begin
      word       = {word[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] word;
    logic [31:0] exp_word;
    logic [31:0] exp_ill;
    logic [31:0] exp_cmp;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      abort_run();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        // comment and blank lines do not parse as four fields
        fields = $sscanf(line, "%h %h %h %h", word, exp_word, exp_ill, exp_cmp);
        if (fields == 4) begin
          stim_word_q.push_back(word);
          stim_instr_q.push_back(exp_word);
          stim_illegal_q.push_back(exp_ill[0]);
          stim_compressed_q.push_back(exp_cmp[0]);
        end
      end
    end
    $fclose(fd);
    if (stim_word_q.size() == 0) begin
      $display("no vectors found in the stimulus file");
      abort_run();
    end
  endtask

  task automatic drive_word(input rvc_pkg::instr_t word, input rvc_pkg::instr_t e_instr,
                            input logic e_illegal, input logic e_compressed);
    @(posedge clk);
    #(DRIVE_DELAY);
    valid = 1'b1;
    instr = word;
    exp_instr_q.push_back(e_instr);
    exp_illegal_q.push_back(e_illegal);
    exp_compressed_q.push_back(e_compressed);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #(DRIVE_DELAY);
    valid = 1'b0;
    instr = '0;
  endtask

  // --------------------
  // stimulus
  // --------------------
  initial begin : driver
    int              cycles;
    rvc_pkg::instr_t word;
    valid = 1'b0;
    instr = '0;
    load_vectors();

    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        $display("timeout: reset was never released");
        abort_run();
      end
    end

    // quiet cycles so valid_o is seen low after reset
    repeat (3) drive_idle();

    for (int i = 0; i < stim_word_q.size(); i++) begin
      drive_word(stim_word_q[i], stim_instr_q[i], stim_illegal_q[i], stim_compressed_q[i]);
      if (i % GAP_EVERY == GAP_EVERY - 1) begin
        drive_idle();
      end
    end

    // full-width words go through untouched
    for (int i = 0; i < NUM_RANDOM; i++) begin
      take_random_word(word);
      word[1:0] = rvc_pkg::QUAD_NONE;
      drive_word(word, word, 1'b0, 1'b0);
    end
    drive_idle();

    cycles = 0;
    while (exp_instr_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        $display("timeout: valid_o never delivered the remaining %0d words",
                 exp_instr_q.size());
        abort_run();
      end
    end

    repeat (2) drive_idle();
    $display("Finished with no errors");
    $finish;
  end

  // --------------------
  // response checking
  // --------------------
  // outputs are sampled on the falling edge, half a cycle after they change
  initial begin : monitor
    logic            exp_valid;
    rvc_pkg::instr_t e_instr;
    logic            e_illegal;
    logic            e_compressed;
    exp_valid = 1'b0;
    forever begin
      @(negedge clk);
      check_flag("valid_o", out_valid, exp_valid);
      if (out_valid === 1'b1) begin
        if (exp_instr_q.size() == 0) begin
          $display("valid_o went high with no word in flight");
          abort_run();
        end else begin
          e_instr      = exp_instr_q.pop_front();
          e_illegal    = exp_illegal_q.pop_front();
          e_compressed = exp_compressed_q.pop_front();
          check_instr("instr_o", out_instr, e_instr);
          check_flag("illegal_o", out_illegal, e_illegal);
          check_flag("compressed_o", out_compressed, e_compressed);
        end
      end
      // the word presented now comes out one edge later
      exp_valid = valid;
    end
  end

endmodule

// File: sim/rvc_stimulus.txt
// columns: input word, expected instr_o, expected illegal_o, expected compressed_o (all hex)
// text after the fourth column is a note
00000800 01010413 0 1  c.addi4spn x8, sp, 16
000040e8 0444a503 0 1  c.lw x10, 68(x9)
0000d60c 02b62423 0 1  c.sw x11, 40(x12)
ffff0001 00000013 0 1  c.nop, upper parcel ignored
00001575 ffd50513 0 1  c.addi x10, -3
00002201 100000ef 0 1  c.jal +256
00005781 fe000793 0 1  c.li x15, -32
00007285 fffe12b7 0 1  c.lui x5, 0xfffe1
00007139 fc010113 0 1  c.addi16sp sp, -64
0000800d 00345413 0 1  c.srli x8, 3
00008495 4054d493 0 1  c.srai x9, 5
0000997d fff57513 0 1  c.andi x10, -1
00008c05 40940433 0 1  c.sub x8, x9
00008d2d 00b54533 0 1  c.xor x10, x11
00008e55 00d66633 0 1  c.or x12, x13
00008f7d 00f77733 0 1  c.and x14, x15
0000bff5 ffdff06f 0 1  c.j -4
0000c401 00040463 0 1  c.beqz x8, +8
0000fcfd fe049fe3 0 1  c.bnez x9, -2
00000592 00459593 0 1  c.slli x11, 4
00004632 00c12603 0 1  c.lwsp x12, 12(sp)
0000c336 08d12223 0 1  c.swsp x13, 132(sp)
00008282 00028067 0 1  c.jr x5
0000852e 00b00533 0 1  c.mv x10, x11
00009002 00100073 0 1  c.ebreak
00009302 000300e7 0 1  c.jalr x6
00009426 00940433 0 1  c.add x8, x9
abcd0004 abcd0004 1 1  c.addi4spn zero immediate
12340000 12340000 1 1  all-zero parcel
00006281 00006281 1 1  c.lui x5 zero immediate
00006101 00006101 1 1  c.addi16sp zero immediate
00004012 00004012 1 1  c.lwsp to x0
00008002 00008002 1 1  c.jr x0
00006048 00006048 1 1  c.flw
00002082 00002082 1 1  c.fldsp
00008048 00008048 1 1  reserved quadrant 0 row
00009c05 00009c05 1 1  c.subw
00009c65 00009c65 1 1  Zcb slot of the misc-ALU row
00a50533 00a50533 0 0  add x10, x10, x10 uncompressed

// File: compile.f
design/rvc_pkg.sv
design/rvc_quadrant0.sv
design/rvc_quadrant1.sv
design/rvc_quadrant2.sv
design/rvc_expander.sv
sim/tb_clock_gen.sv
sim/tb_rvc_expander.sv

// File: Bender.yml
package:
  name: rvc_expander

sources:
  - design/rvc_pkg.sv
  - design/rvc_quadrant0.sv
  - design/rvc_quadrant1.sv
  - design/rvc_quadrant2.sv
  - design/rvc_expander.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_rvc_expander.sv
